// File: common/noc_pkg.sv
package noc_pkg;

   // one flit word plus the eof bit
   localparam int flit_w    = 32;
   localparam int coord_w   = 8;   // same width as the mesh addrx and addry
   localparam int num_ports = 5;

   // destination fields of a head flit
   localparam int dst_x_lsb = 8;   // dst x in data[15:8]
   localparam int dst_y_lsb = 0;   // dst y in data[7:0]

   typedef logic [flit_w-1:0] data_t;

   typedef logic [coord_w-1:0] coord_t;

   // one bit per port indexed by port_id_e
   typedef logic [num_ports-1:0] port_vec_t;

   // port order s, w, n, e, l
   typedef enum logic [2:0] {
      port_s = 3'd0,
      port_w = 3'd1,
      port_n = 3'd2,
      port_e = 3'd3,
      port_l = 3'd4
   } port_id_e;

   typedef struct packed {
      data_t data;
      logic  eof;   // last flit of a packet
   } flit_t;

endpackage

// File: common/router_pkg.sv
package router_pkg;

   // input fifo depth as a power of two
   localparam int buf_depth = 4;
   localparam int ptr_w     = $clog2(buf_depth);

   // fifo pointer with the wrap bit on top
   typedef logic [ptr_w:0] ptr_t;

   // one-hot input select for an output
   typedef logic [noc_pkg::num_ports-1:0] grant_t;

   // per-output wormhole lock
   typedef enum logic {
      alloc_idle,
      alloc_locked
   } alloc_state_e;

endpackage

// File: router/input_port.sv
module input_port (
   input  logic              clk,
   input  logic              rst_n,
   input  noc_pkg::coord_t   addrx,
   input  noc_pkg::coord_t   addry,
   input  noc_pkg::flit_t    in_flit,
   input  logic              in_valid,
   output logic              in_ack,
   input  logic              pop,
   output noc_pkg::flit_t    head_flit,
   output logic              head_valid,
   output noc_pkg::port_id_e head_route
);
   import noc_pkg::*;
   import router_pkg::*;

   flit_t    mem [buf_depth];
   ptr_t     wr_ptr;
   ptr_t     rd_ptr;
   logic     full;
   logic     empty;
   logic     push;
   logic     do_pop;
   logic     pkt_start;   // next head flit opens a packet
   port_id_e route_q;
   port_id_e route_calc;
   coord_t   dst_x;
   coord_t   dst_y;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                  (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

   // ack goes out in the same cycle the flit is taken
   assign push   = in_valid && !full;
   assign in_ack = push;
   assign do_pop = pop && !empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[ptr_w-1:0]] <= in_flit;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign head_flit  = mem[rd_ptr[ptr_w-1:0]];
   assign head_valid = !empty;

   assign dst_x = head_flit.data[dst_x_lsb +: coord_w];
   assign dst_y = head_flit.data[dst_y_lsb +: coord_w];

   // x is resolved before y
   always_comb begin
      if (dst_x > addrx) begin
         route_calc = port_e;
      end else if (dst_x < addrx) begin
         route_calc = port_w;
      end else if (dst_y > addry) begin
         route_calc = port_n;
      end else if (dst_y < addry) begin
         route_calc = port_s;
      end else begin
         route_calc = port_l;   // arrived
      end
   end

   // keep the head route for the body flits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_start <= 1'b1;
         route_q   <= port_l;
      end else if (do_pop) begin
         pkt_start <= head_flit.eof;   // tail pop means a new packet next
         if (pkt_start) begin
            route_q <= route_calc;
         end
      end
   end

   assign head_route = pkt_start ? route_calc : route_q;

endmodule

// File: router/switch_alloc.sv
module switch_alloc (
   input  logic               clk,
   input  logic               rst_n,
   input  noc_pkg::port_vec_t head_valid,
   input  noc_pkg::port_id_e  head_route [noc_pkg::num_ports],
   input  noc_pkg::port_vec_t head_eof,
   input  noc_pkg::port_vec_t out_ready,
   output noc_pkg::port_vec_t pop,
   output router_pkg::grant_t sel [noc_pkg::num_ports],
   output noc_pkg::port_vec_t load
);
   import noc_pkg::*;
   import router_pkg::*;

   alloc_state_e state [num_ports];
   grant_t       owner [num_ports];   // last winner that holds the output while locked
   grant_t       req   [num_ports];
   grant_t       pick  [num_ports];
   port_vec_t    tail;                // loaded flit closes the packet

   // first requester after the last winner
   function automatic grant_t rr_pick(grant_t req_v, grant_t last_v);
      grant_t pick_v;
      int     base;
      int     idx;
      pick_v = '0;
      base   = 0;
      for (int i = 0; i < num_ports; i++) begin
         if (last_v[i]) begin
            base = i + 1;
         end
      end
      // walk backwards so the nearest requester is written last
      for (int k = num_ports - 1; k >= 0; k--) begin
         idx = (base + k) % num_ports;
         if (req_v[idx]) begin
            pick_v      = '0;
            pick_v[idx] = 1'b1;
         end
      end
      return pick_v;
   endfunction

   always_comb begin
      pop = '0;
      for (int o = 0; o < num_ports; o++) begin
         for (int i = 0; i < num_ports; i++) begin
            req[o][i] = head_valid[i] && (head_route[i] == port_id_e'(o));
         end
         pick[o] = rr_pick(req[o], owner[o]);
         // idle outputs grant and load in the same cycle
         sel[o]  = (state[o] == alloc_idle) ? pick[o] : owner[o];
         load[o] = (|(sel[o] & head_valid)) && out_ready[o];
         tail[o] = |(sel[o] & head_eof);
         if (load[o]) begin
            pop = pop | sel[o];   // an input feeds one output only
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int o = 0; o < num_ports; o++) begin
            state[o] <= alloc_idle;
            owner[o] <= '0;
         end
      end else begin
         for (int o = 0; o < num_ports; o++) begin
            case (state[o])
               alloc_idle: begin
                  if (|pick[o]) begin
                     owner[o] <= pick[o];
                     // a single flit packet leaves the output free
                     if (!(load[o] && tail[o])) begin
                        state[o] <= alloc_locked;
                     end
                  end
               end
               alloc_locked: begin
                  if (load[o] && tail[o]) begin
                     state[o] <= alloc_idle;
                  end
               end
               default: state[o] <= alloc_idle;
            endcase
         end
      end
   end

endmodule

// File: router/output_port.sv
module output_port (
   input  logic               clk,
   input  logic               rst_n,
   input  router_pkg::grant_t sel,
   input  logic               load,
   input  noc_pkg::flit_t     head_flit [noc_pkg::num_ports],
   output noc_pkg::flit_t     out_flit,
   output logic               out_valid,
   input  logic               out_ack,
   output logic               out_ready
);
   import noc_pkg::*;

   flit_t mux_flit;

   // one-hot crossbar column
   always_comb begin
      mux_flit = head_flit[0];
      for (int i = 0; i < num_ports; i++) begin
         if (sel[i]) begin
            mux_flit = head_flit[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ack) begin
         out_valid <= 1'b0;
      end
   end

   // held until the receiver acks
   always_ff @(posedge clk) begin
      if (load) begin
         out_flit <= mux_flit;
      end
   end

   // free now, or freed by the ack at this edge
   assign out_ready = !out_valid || out_ack;

endmodule

// File: router/router.sv
module router (
   input  logic               clk,
   input  logic               rst_n,
   input  noc_pkg::coord_t    addrx,
   input  noc_pkg::coord_t    addry,
   input  noc_pkg::flit_t     in_flit [noc_pkg::num_ports],
   input  noc_pkg::port_vec_t in_valid,
   output noc_pkg::port_vec_t in_ack,
   output noc_pkg::flit_t     out_flit [noc_pkg::num_ports],
   output noc_pkg::port_vec_t out_valid,
   input  noc_pkg::port_vec_t out_ack
);
   import noc_pkg::*;
   import router_pkg::*;

   flit_t     head_flit  [num_ports];
   port_vec_t head_valid;
   port_id_e  head_route [num_ports];
   port_vec_t head_eof;
   port_vec_t pop;
   grant_t    sel [num_ports];
   port_vec_t load;
   port_vec_t out_ready;

   always_comb begin
      for (int i = 0; i < num_ports; i++) begin
         head_eof[i] = head_flit[i].eof;
      end
   end

   // input side from south to local
   input_port input_port_s (
      .clk, .rst_n, .addrx, .addry,
      .in_flit(in_flit[port_s]), .in_valid(in_valid[port_s]), .in_ack(in_ack[port_s]),
      .pop(pop[port_s]), .head_flit(head_flit[port_s]),
      .head_valid(head_valid[port_s]), .head_route(head_route[port_s])
   );

   input_port input_port_w (
      .clk, .rst_n, .addrx, .addry,
      .in_flit(in_flit[port_w]), .in_valid(in_valid[port_w]), .in_ack(in_ack[port_w]),
      .pop(pop[port_w]), .head_flit(head_flit[port_w]),
      .head_valid(head_valid[port_w]), .head_route(head_route[port_w])
   );

   input_port input_port_n (
      .clk, .rst_n, .addrx, .addry,
      .in_flit(in_flit[port_n]), .in_valid(in_valid[port_n]), .in_ack(in_ack[port_n]),
      .pop(pop[port_n]), .head_flit(head_flit[port_n]),
      .head_valid(head_valid[port_n]), .head_route(head_route[port_n])
   );

   input_port input_port_e (
      .clk, .rst_n, .addrx, .addry,
      .in_flit(in_flit[port_e]), .in_valid(in_valid[port_e]), .in_ack(in_ack[port_e]),
      .pop(pop[port_e]), .head_flit(head_flit[port_e]),
      .head_valid(head_valid[port_e]), .head_route(head_route[port_e])
   );

   input_port input_port_l (
      .clk, .rst_n, .addrx, .addry,
      .in_flit(in_flit[port_l]), .in_valid(in_valid[port_l]), .in_ack(in_ack[port_l]),
      .pop(pop[port_l]), .head_flit(head_flit[port_l]),
      .head_valid(head_valid[port_l]), .head_route(head_route[port_l])
   );

   switch_alloc switch_alloc_i (
      .clk, .rst_n, .head_valid, .head_route, .head_eof, .out_ready,
      .pop, .sel, .load
   );

   // output side in the same port order
   for (genvar o = 0; o < num_ports; o++) begin : gen_out
      output_port output_port_i (
         .clk, .rst_n, .sel(sel[o]), .load(load[o]), .head_flit,
         .out_flit(out_flit[o]), .out_valid(out_valid[o]), .out_ack(out_ack[o]),
         .out_ready(out_ready[o])
      );
   end

endmodule

// File: tests/tb_router.sv
module tb_router;
   import noc_pkg::*;

   localparam int     pkts_per_port = 30;
   localparam int     max_flits     = 128;
   localparam int     num_tests     = 6;
   // 150 packets, up to 4 flits, 5 ports, about one ack in two cycles
   localparam int     limit_cycles  = 150 * 4 * num_ports * 4 + 200;
   localparam coord_t my_x          = 8'd3;
   localparam coord_t my_y          = 8'd3;

   logic      clk;
   logic      rst_n;
   coord_t    addrx;
   coord_t    addry;
   flit_t     in_flit  [num_ports];
   port_vec_t in_valid;
   port_vec_t in_ack;
   flit_t     out_flit [num_ports];
   port_vec_t out_valid;
   port_vec_t out_ack;

   integer    seed;
   flit_t     stim     [num_ports][max_flits];
   int        stim_len [num_ports];
   int        stim_pos [num_ports];
   port_vec_t accepted;                 // taken at the last rising edge
   port_vec_t in_head;                  // next accepted flit opens a packet
   int        route_of [num_ports];

   // expected flits in one lane per source and output pair
   flit_t     exp_mem [num_ports*num_ports][max_flits];
   int        exp_wr  [num_ports*num_ports];
   int        exp_rd  [num_ports*num_ports];

   port_vec_t out_busy;                 // output inside a packet
   int        out_owner [num_ports];
   port_vec_t prev_hold;                // valid without ack at the last edge
   flit_t     prev_flit [num_ports];

   int        errs [num_tests];
   int        cycles;
   int        total_flits;
   int        sent_flits;
   int        got_flits;
   int        first_round;              // first packets seen on east
   int        tests_ok;
   int        err_sum;

   router dut_i (
      .clk, .rst_n, .addrx, .addry,
      .in_flit, .in_valid, .in_ack,
      .out_flit, .out_valid, .out_ack
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // x first, then y
   function automatic int xy_route(coord_t x, coord_t y);
      if (x > my_x) begin
         return int'(port_e);
      end else if (x < my_x) begin
         return int'(port_w);
      end else if (y > my_y) begin
         return int'(port_n);
      end else if (y < my_y) begin
         return int'(port_s);
      end
      return int'(port_l);
   endfunction

   task automatic log_mismatch(int t, string sig, logic [32:0] got, logic [32:0] want);
      $display("[ERROR] %s = %h, expected %h", sig, got, want);
      errs[t]++;
   endtask

   task automatic describe_failure(int t, string msg);
      $display("%s", msg);
      errs[t]++;
   endtask

   task automatic print_result(int t, string name);
      $display("test %0d %s: %s, %0d errors", t, name,
               (errs[t] == 0) ? "ok" : "FAILED", errs[t]);
   endtask

   // data holds src[31:28] pkt[27:20] idx[19:16] and the head carries dst x and y
   task automatic make_packets();
      int     n;
      int     len;
      coord_t dx;
      coord_t dy;
      data_t  d;
      for (int p = 0; p < num_ports; p++) begin
         n = 0;
         for (int k = 0; k < pkts_per_port; k++) begin
            len = 1 + int'($unsigned($random(seed)) % 4);
            dx  = coord_t'($unsigned($random(seed)) % 8);
            dy  = coord_t'($unsigned($random(seed)) % 8);
            if (k < 2) begin
               dx = 8'd6;   // every source into east at once
               dy = my_y;
            end else if (k == 2) begin
               dx = my_x;   // local delivery
               dy = my_y;
            end
            for (int f = 0; f < len; f++) begin
               if (f == 0) begin
                  d = {4'(p), 8'(k), 4'(f), dx, dy};
               end else begin
                  d = {4'(p), 8'(k), 4'(f), 16'($random(seed))};
               end
               stim[p][n].data = d;
               stim[p][n].eof  = (f == len - 1);
               n++;
            end
         end
         stim_len[p] = n;
         total_flits += n;
      end
   endtask

   task automatic check_reset();
      assert (out_valid == '0) else log_mismatch(0, "out_valid", 33'(out_valid), 33'(0));
      assert (in_ack == '0) else log_mismatch(0, "in_ack", 33'(in_ack), 33'(0));
   endtask

   task automatic drive_inputs();
      for (int p = 0; p < num_ports; p++) begin
         if (accepted[p]) begin
            stim_pos[p]++;
         end
         if (stim_pos[p] < stim_len[p]) begin
            in_valid[p] = 1'b1;
            in_flit[p]  = stim[p][stim_pos[p]];
         end else begin
            in_valid[p] = 1'b0;
            in_flit[p]  = '0;
         end
      end
      if ((cycles % 64) >= 48) begin
         out_ack = '0;   // stall phase
      end else begin
         out_ack = port_vec_t'($random(seed));
      end
   endtask

   task automatic record_input(int p);
      flit_t f;
      int    q;
      f = in_flit[p];
      if (in_head[p]) begin
         route_of[p] = xy_route(f.data[15:8], f.data[7:0]);
      end
      q = p * num_ports + route_of[p];
      exp_mem[q][exp_wr[q]] = f;
      exp_wr[q]++;
      in_head[p] = f.eof;
      sent_flits++;
   endtask

   task automatic check_fairness(flit_t f);
      int pkt;
      pkt = int'(f.data[27:20]);
      if (pkt == 0) begin
         first_round++;
      end else if (pkt == 1) begin
         assert (first_round == num_ports) else describe_failure(5,
            $sformatf("source %0d got a second packet on east before all sources had one",
                      f.data[31:28]));
      end
   endtask

   task automatic check_output(int o);
      flit_t f;
      int    src;
      int    q;
      f   = out_flit[o];
      src = int'(f.data[31:28]);
      got_flits++;
      if (out_busy[o]) begin
         assert (src == out_owner[o]) else log_mismatch(3,
            $sformatf("out_flit[%0d] source", o), 33'(src), 33'(out_owner[o]));
      end else begin
         assert (xy_route(f.data[15:8], f.data[7:0]) == o) else describe_failure(1,
            $sformatf("head flit %h left on output %0d, the wrong route", f.data, o));
         out_owner[o] = src;
         if (o == int'(port_e)) begin
            check_fairness(f);
         end
      end
      out_busy[o] = !f.eof;
      assert (src < num_ports) else describe_failure(2,
         $sformatf("output %0d delivered a flit from unknown source %0d", o, src));
      if (src < num_ports) begin
         q = src * num_ports + o;
         assert (exp_rd[q] < exp_wr[q]) else describe_failure(2,
            $sformatf("output %0d delivered a flit that source %0d never sent there", o, src));
         if (exp_rd[q] < exp_wr[q]) begin
            assert (f == exp_mem[q][exp_rd[q]]) else log_mismatch(2,
               $sformatf("out_flit[%0d]", o), f, exp_mem[q][exp_rd[q]]);
            exp_rd[q]++;
         end
      end
   endtask

   // handshakes are sampled at the rising edge
   always @(posedge clk) begin
      if (rst_n) begin
         cycles++;
         for (int p = 0; p < num_ports; p++) begin
            accepted[p] = in_valid[p] && in_ack[p];
            if (accepted[p]) begin
               record_input(p);
            end
         end
         for (int o = 0; o < num_ports; o++) begin
            if (prev_hold[o]) begin
               assert (out_valid[o]) else log_mismatch(4,
                  $sformatf("out_valid[%0d]", o), 33'(out_valid[o]), 33'(1));
               assert (out_flit[o] == prev_flit[o]) else log_mismatch(4,
                  $sformatf("out_flit[%0d]", o), out_flit[o], prev_flit[o]);
            end
            if (out_valid[o] && out_ack[o]) begin
               check_output(o);
            end
            prev_hold[o] = out_valid[o] && !out_ack[o];
            prev_flit[o] = out_flit[o];
         end
      end
   end

   initial begin
      seed        = 89;
      rst_n       = 1'b0;
      addrx       = my_x;
      addry       = my_y;
      in_valid    = '0;
      out_ack     = '0;
      accepted    = '0;
      in_head     = '1;
      out_busy    = '0;
      prev_hold   = '0;
      cycles      = 0;
      total_flits = 0;
      sent_flits  = 0;
      got_flits   = 0;
      first_round = 0;
      for (int p = 0; p < num_ports; p++) begin
         in_flit[p]   = '0;
         stim_pos[p]  = 0;
         route_of[p]  = 0;
         out_owner[p] = 0;
         prev_flit[p] = '0;
      end
      for (int q = 0; q < num_ports * num_ports; q++) begin
         exp_wr[q] = 0;
         exp_rd[q] = 0;
      end
      for (int t = 0; t < num_tests; t++) begin
         errs[t] = 0;
      end
      make_packets();

      repeat (8) begin
         @(posedge clk);
         check_reset();
      end
      @(negedge clk);
      rst_n = 1'b1;
      @(posedge clk);
      check_reset();   // first cycle out of reset, inputs still idle
      print_result(0, "reset");

      while (got_flits < total_flits && cycles <= limit_cycles) begin
         @(negedge clk);
         drive_inputs();
      end

      if (cycles > limit_cycles) begin
         $display("timeout: run stalled after %0d cycles with %0d of %0d flits outstanding",
                  cycles, total_flits - got_flits, total_flits);
         $display("tests failed");
         $finish;
      end else begin
         assert (sent_flits == total_flits) else describe_failure(4,
            $sformatf("only %0d of %0d flits were accepted", sent_flits, total_flits));
         assert (out_valid == '0) else log_mismatch(4, "out_valid", 33'(out_valid), 33'(0));
         for (int q = 0; q < num_ports * num_ports; q++) begin
            assert (exp_rd[q] == exp_wr[q]) else describe_failure(4,
               $sformatf("source %0d to output %0d still misses %0d flits",
                         q / num_ports, q % num_ports, exp_wr[q] - exp_rd[q]));
         end
         assert (first_round == num_ports) else describe_failure(5,
            $sformatf("only %0d first packets reached east", first_round));
         print_result(1, "routing");
         print_result(2, "integrity and order");
         print_result(3, "wormhole exclusivity");
         print_result(4, "back-pressure");
         print_result(5, "fairness");
         tests_ok = 0;
         err_sum  = 0;
         for (int t = 0; t < num_tests; t++) begin
            err_sum += errs[t];
            if (errs[t] == 0) begin
               tests_ok++;
            end
         end
         $display("%0d of %0d tests ok, %0d errors in total", tests_ok, num_tests, err_sum);
         if (err_sum == 0) begin
            $display("all tests passed");
         end else begin
            $display("tests failed");
         end
         $finish;
      end
   end

endmodule

// File: vlog.f
common/noc_pkg.sv
common/router_pkg.sv
router/input_port.sv
router/switch_alloc.sv
router/output_port.sv
router/router.sv
tests/tb_router.sv

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_router -f vlog.f -o tb_router

# pass or fail is read from the simulation output
sim_out=$(./obj_dir/tb_router)
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
   exit 0
else
   exit 1
fi
